/* fb_pkg.sv */
`default_nettype none

package fb_pkg;

   localparam int fb_aw      = 25;
   localparam int fb_dw      = 32;
   localparam int sdr_dw     = 16;
   localparam int sdr_cmd_aw = fb_aw - 2;   // Word address toward SDRAM
   localparam int l2_lines   = 64;
   localparam int l2_words   = 4;
   localparam int l2_bst_len = l2_words * fb_dw / sdr_dw;

   localparam int l2_idx_w   = $clog2(l2_lines);
   localparam int l2_off_w   = $clog2(l2_words);
   localparam int l2_tag_w   = fb_aw - l2_idx_w - l2_off_w - 2;
   localparam int l2_line_w  = fb_dw * l2_words;

   // Cache FSM
   localparam logic [2:0] st_init   = 3'd0;
   localparam logic [2:0] st_idle   = 3'd1;
   localparam logic [2:0] st_lookup = 3'd2;
   localparam logic [2:0] st_wb     = 3'd3;
   localparam logic [2:0] st_refill = 3'd4;
   localparam logic [2:0] st_resp   = 3'd5;
   localparam logic [2:0] st_flush  = 3'd6;

   typedef struct packed {
      logic [l2_tag_w-1:0] tag;
      logic [l2_idx_w-1:0] idx;
      logic [l2_off_w-1:0] word;
      logic [1:0]          boff;   // Byte in word
   } l2_fields_t;

   // Flat byte address or cache fields
   typedef union packed {
      logic [fb_aw-1:0] flat;
      l2_fields_t       f;
   } l2_addr_t;

endpackage

`default_nettype wire

/* fb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          ibus_cmd_valid,
   output logic                         ibus_cmd_ready,
   input  wire [fb_pkg::fb_aw-1:0]      ibus_cmd_addr,
   output logic                         ibus_valid,
   input  wire                          ibus_ready,
   output logic [fb_pkg::fb_dw-1:0]     ibus_dout,
   input  wire                          dbus_cmd_valid,
   output logic                         dbus_cmd_ready,
   input  wire [fb_pkg::fb_aw-1:0]      dbus_cmd_addr,
   input  wire [fb_pkg::fb_dw/8-1:0]    dbus_cmd_we_msk,
   input  wire [fb_pkg::fb_dw-1:0]      dbus_din,
   output logic                         dbus_valid,
   input  wire                          dbus_ready,
   output logic [fb_pkg::fb_dw-1:0]     dbus_dout,
   output logic                         mbus_cmd_valid,
   input  wire                          mbus_cmd_ready,
   output logic [fb_pkg::fb_aw-1:0]     mbus_cmd_addr,
   output logic [fb_pkg::fb_dw/8-1:0]   mbus_cmd_we_msk,
   output logic [fb_pkg::fb_dw-1:0]     mbus_din,
   input  wire                          mbus_valid,
   output logic                         mbus_ready,
   input  wire [fb_pkg::fb_dw-1:0]      mbus_dout
);

   logic busy;    // Grant locked until response accepted
   logic own_d;   // Locked grant belongs to dbus
   logic sel_d;

   assign sel_d = dbus_cmd_valid;   // Fixed priority to dbus

   assign mbus_cmd_valid  = !busy && (dbus_cmd_valid || ibus_cmd_valid);
   assign mbus_cmd_addr   = sel_d ? dbus_cmd_addr : ibus_cmd_addr;
   assign mbus_cmd_we_msk = sel_d ? dbus_cmd_we_msk : '0;   // ibus only reads
   assign mbus_din        = dbus_din;

   assign dbus_cmd_ready = !busy && mbus_cmd_ready;
   assign ibus_cmd_ready = !busy && !dbus_cmd_valid && mbus_cmd_ready;

   // Response steering
   assign mbus_ready = busy && (own_d ? dbus_ready : ibus_ready);
   assign dbus_valid = busy && own_d && mbus_valid;
   assign ibus_valid = busy && !own_d && mbus_valid;
   assign dbus_dout  = mbus_dout;
   assign ibus_dout  = mbus_dout;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy  <= 1'b0;
         own_d <= 1'b0;
      end else if (mbus_cmd_valid && mbus_cmd_ready) begin
         busy  <= 1'b1;
         own_d <= sel_d;
      end else if (mbus_valid && mbus_ready) begin
         busy  <= 1'b0;
      end
   end

   a_grant_held: assert property (@(posedge clk) disable iff (rst)
      busy && !(mbus_valid && mbus_ready) |=> busy && $stable(own_d));

endmodule

`default_nettype wire

/* sdr_burst_xfer.sv */
`timescale 1ns/1ps
`default_nettype none

module sdr_burst_xfer (
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            start_rd,
   input  wire                            start_we,
   input  wire fb_pkg::l2_addr_t          line_addr,
   input  wire [fb_pkg::l2_line_w-1:0]    wr_line,
   output logic [fb_pkg::l2_line_w-1:0]   rd_line,
   output logic                           done,
   output logic                           sdr_cmd_bst_rd_req,
   output logic                           sdr_cmd_bst_we_req,
   input  wire                            sdr_cmd_bst_rd_ack,
   input  wire                            sdr_cmd_bst_we_ack,
   output logic [fb_pkg::sdr_cmd_aw-1:0]  sdr_cmd_addr,
   output logic [fb_pkg::sdr_dw-1:0]      sdr_din,
   input  wire [fb_pkg::sdr_dw-1:0]       sdr_dout,
   input  wire                            sdr_r_vld,
   input  wire                            sdr_w_rdy
);

   import fb_pkg::*;

   logic                          rd_act;
   logic                          we_act;
   logic [$clog2(l2_bst_len)-1:0] cnt;       // Halfwords moved
   logic [l2_line_w-1:0]          line_buf;
   logic                          strobe;

   assign strobe  = (rd_act && sdr_r_vld) || (we_act && sdr_w_rdy);
   assign rd_line = line_buf;
   assign sdr_din = line_buf[sdr_dw-1:0];   // Low half first

   always_ff @(posedge clk) begin
      if (rst) begin
         sdr_cmd_bst_rd_req <= 1'b0;
         sdr_cmd_bst_we_req <= 1'b0;
         rd_act             <= 1'b0;
         we_act             <= 1'b0;
         cnt                <= '0;
         done               <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start_rd) begin
            sdr_cmd_bst_rd_req <= 1'b1;
            rd_act             <= 1'b1;
         end
         if (start_we) begin
            sdr_cmd_bst_we_req <= 1'b1;
            we_act             <= 1'b1;
         end
         if (sdr_cmd_bst_rd_ack)
            sdr_cmd_bst_rd_req <= 1'b0;
         if (sdr_cmd_bst_we_ack)
            sdr_cmd_bst_we_req <= 1'b0;
         if (strobe) begin
            cnt <= cnt + 1'b1;
            if (cnt == $bits(cnt)'(l2_bst_len - 1)) begin
               rd_act <= 1'b0;
               we_act <= 1'b0;
               done   <= 1'b1;
            end
         end
      end
   end

   // One shifter serves both directions
   always_ff @(posedge clk) begin
      if (start_rd || start_we)
         sdr_cmd_addr <= line_addr.flat[fb_aw-1:2];
      if (start_we)
         line_buf <= wr_line;
      else if (strobe)
         line_buf <= {sdr_dout, line_buf[l2_line_w-1:sdr_dw]};
   end

   a_one_req: assert property (@(posedge clk) disable iff (rst)
      !(sdr_cmd_bst_rd_req && sdr_cmd_bst_we_req));

   a_start_idle: assert property (@(posedge clk) disable iff (rst)
      (start_rd || start_we) |-> !(rd_act || we_act));

endmodule

`default_nettype wire

/* l2_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache (
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            cmd_valid,
   output logic                           cmd_ready,
   input  wire fb_pkg::l2_addr_t          cmd_addr,
   input  wire [fb_pkg::fb_dw/8-1:0]      cmd_we_msk,
   input  wire [fb_pkg::fb_dw-1:0]        din,
   output logic                           valid,
   input  wire                            ready,
   output logic [fb_pkg::fb_dw-1:0]       dout,
   input  wire                            flush,
   output logic                           flush_done,
   output logic                           sdr_cmd_bst_rd_req,
   output logic                           sdr_cmd_bst_we_req,
   input  wire                            sdr_cmd_bst_rd_ack,
   input  wire                            sdr_cmd_bst_we_ack,
   output logic [fb_pkg::sdr_cmd_aw-1:0]  sdr_cmd_addr,
   output logic [fb_pkg::sdr_dw-1:0]      sdr_din,
   input  wire [fb_pkg::sdr_dw-1:0]       sdr_dout,
   input  wire                            sdr_r_vld,
   input  wire                            sdr_w_rdy
);

   import fb_pkg::*;

   logic [2:0]           state;
   logic [l2_idx_w-1:0]  idx_cnt;      // Init and flush walk
   logic                 fl_wait;
   logic                 flush_pend;
   logic                 pend_r;
   l2_addr_t             addr_r;
   logic [fb_dw/8-1:0]   msk_r;
   logic [fb_dw-1:0]     din_r;
   logic [fb_dw-1:0]     dout_r;

   logic [l2_lines-1:0]  vld_r;
   logic [l2_lines-1:0]  dirty_r;
   logic [l2_tag_w-1:0]  tag_r [l2_lines];
   logic [l2_line_w-1:0] line_r [l2_lines];

   logic [l2_idx_w-1:0]  vidx;
   logic                 hit;
   logic                 victim_dirty;
   logic [fb_dw-1:0]     hit_word;
   l2_addr_t             wb_addr;
   l2_addr_t             rd_addr;
   logic                 start_rd;
   logic                 start_we;
   logic                 bst_done;
   logic [l2_line_w-1:0] rd_line;
   logic                 accept;

   assign cmd_ready = (state == st_idle) && !flush_pend && !flush;
   assign accept    = cmd_valid && cmd_ready;

   assign vidx         = (state == st_flush) ? idx_cnt : addr_r.f.idx;
   assign hit          = vld_r[vidx] && (tag_r[vidx] == addr_r.f.tag);
   assign victim_dirty = vld_r[vidx] && dirty_r[vidx];
   assign hit_word     = line_r[addr_r.f.idx][addr_r.f.word*fb_dw +: fb_dw];

   // Line-aligned burst addresses
   always_comb begin
      wb_addr.f.tag  = tag_r[vidx];
      wb_addr.f.idx  = vidx;
      wb_addr.f.word = '0;
      wb_addr.f.boff = '0;
      rd_addr        = addr_r;
      rd_addr.f.word = '0;
      rd_addr.f.boff = '0;
   end

   assign start_we = ((state == st_lookup) && !hit && victim_dirty) ||
                     ((state == st_flush) && !fl_wait && victim_dirty);
   assign start_rd = ((state == st_lookup) && !hit && !victim_dirty) ||
                     ((state == st_wb) && bst_done);

   // Hit answers straight from lookup
   assign valid = ((state == st_lookup) && hit) || (state == st_resp);
   assign dout  = (state == st_resp) ? dout_r : hit_word;

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= st_init;
         idx_cnt    <= '0;
         fl_wait    <= 1'b0;
         flush_pend <= 1'b0;
         flush_done <= 1'b0;
         pend_r     <= 1'b0;
      end else begin
         flush_done <= 1'b0;
         if (flush)
            flush_pend <= 1'b1;
         if (accept)
            pend_r <= 1'b1;
         else if (valid && ready)
            pend_r <= 1'b0;

         case (state)
            st_init: begin
               vld_r[idx_cnt]   <= 1'b0;
               dirty_r[idx_cnt] <= 1'b0;
               idx_cnt          <= idx_cnt + 1'b1;
               if (idx_cnt == l2_idx_w'(l2_lines - 1))
                  state <= st_idle;
            end
            st_idle: begin
               if (flush_pend || flush) begin
                  flush_pend <= 1'b0;
                  state      <= st_flush;
               end else if (accept) begin
                  addr_r <= cmd_addr;
                  msk_r  <= cmd_we_msk;
                  din_r  <= din;
                  state  <= st_lookup;
               end
            end
            st_lookup: begin
               if (hit) begin
                  for (int b = 0; b < fb_dw/8; b++) begin
                     if (msk_r[b])
                        line_r[addr_r.f.idx][addr_r.f.word*fb_dw + 8*b +: 8] <= din_r[8*b +: 8];
                  end
                  if (|msk_r)
                     dirty_r[addr_r.f.idx] <= 1'b1;
                  dout_r <= hit_word;   // Held if master stalls
                  state  <= ready ? st_idle : st_resp;
               end else begin
                  state <= victim_dirty ? st_wb : st_refill;
               end
            end
            st_wb: begin
               if (bst_done)
                  state <= st_refill;   // Refill launched by start_rd
            end
            st_refill: begin
               if (bst_done) begin
                  line_r[addr_r.f.idx]  <= rd_line;
                  tag_r[addr_r.f.idx]   <= addr_r.f.tag;
                  vld_r[addr_r.f.idx]   <= 1'b1;
                  dirty_r[addr_r.f.idx] <= 1'b0;
                  state                 <= st_lookup;
               end
            end
            st_resp: begin
               if (ready)
                  state <= st_idle;
            end
            st_flush: begin
               if (fl_wait) begin
                  if (bst_done) begin
                     dirty_r[idx_cnt] <= 1'b0;
                     fl_wait          <= 1'b0;
                  end
               end else if (victim_dirty) begin
                  fl_wait <= 1'b1;
               end else begin
                  idx_cnt <= idx_cnt + 1'b1;
                  if (idx_cnt == l2_idx_w'(l2_lines - 1)) begin
                     flush_done <= 1'b1;
                     state      <= st_idle;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   sdr_burst_xfer sdr_burst_xfer_i (
      .clk                (clk),
      .rst                (rst),
      .start_rd           (start_rd),
      .start_we           (start_we),
      .line_addr          (start_we ? wb_addr : rd_addr),
      .wr_line            (line_r[vidx]),
      .rd_line            (rd_line),
      .done               (bst_done),
      .sdr_cmd_bst_rd_req (sdr_cmd_bst_rd_req),
      .sdr_cmd_bst_we_req (sdr_cmd_bst_we_req),
      .sdr_cmd_bst_rd_ack (sdr_cmd_bst_rd_ack),
      .sdr_cmd_bst_we_ack (sdr_cmd_bst_we_ack),
      .sdr_cmd_addr       (sdr_cmd_addr),
      .sdr_din            (sdr_din),
      .sdr_dout           (sdr_dout),
      .sdr_r_vld          (sdr_r_vld),
      .sdr_w_rdy          (sdr_w_rdy)
   );

   a_resp_pending: assert property (@(posedge clk) disable iff (rst)
      valid |-> pend_r);

   a_dirty_valid: assert property (@(posedge clk) disable iff (rst)
      (state != st_init) |-> ((dirty_r & ~vld_r) == '0));

endmodule

`default_nettype wire

/* fb_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_mem_subsys (
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            ibus_cmd_valid,
   output logic                           ibus_cmd_ready,
   input  wire [fb_pkg::fb_aw-1:0]        ibus_cmd_addr,
   output logic                           ibus_valid,
   input  wire                            ibus_ready,
   output logic [fb_pkg::fb_dw-1:0]       ibus_dout,
   input  wire                            dbus_cmd_valid,
   output logic                           dbus_cmd_ready,
   input  wire [fb_pkg::fb_aw-1:0]        dbus_cmd_addr,
   input  wire [fb_pkg::fb_dw/8-1:0]      dbus_cmd_we_msk,
   input  wire [fb_pkg::fb_dw-1:0]        dbus_din,
   output logic                           dbus_valid,
   input  wire                            dbus_ready,
   output logic [fb_pkg::fb_dw-1:0]       dbus_dout,
   input  wire                            flush,
   output logic                           flush_done,
   output logic                           sdr_cmd_bst_rd_req,
   output logic                           sdr_cmd_bst_we_req,
   input  wire                            sdr_cmd_bst_rd_ack,
   input  wire                            sdr_cmd_bst_we_ack,
   output logic [fb_pkg::sdr_cmd_aw-1:0]  sdr_cmd_addr,
   output logic [fb_pkg::sdr_dw-1:0]      sdr_din,
   input  wire [fb_pkg::sdr_dw-1:0]       sdr_dout,
   input  wire                            sdr_r_vld,
   input  wire                            sdr_w_rdy
);

   import fb_pkg::*;

   logic               mbus_cmd_valid;
   logic               mbus_cmd_ready;
   logic [fb_aw-1:0]   mbus_cmd_addr;   // Flat view of l2_addr_t
   logic [fb_dw/8-1:0] mbus_cmd_we_msk;
   logic [fb_dw-1:0]   mbus_din;
   logic               mbus_valid;
   logic               mbus_ready;
   logic [fb_dw-1:0]   mbus_dout;

   fb_arbiter fb_arbiter_i (
      .clk,
      .rst,
      .ibus_cmd_valid,
      .ibus_cmd_ready,
      .ibus_cmd_addr,
      .ibus_valid,
      .ibus_ready,
      .ibus_dout,
      .dbus_cmd_valid,
      .dbus_cmd_ready,
      .dbus_cmd_addr,
      .dbus_cmd_we_msk,
      .dbus_din,
      .dbus_valid,
      .dbus_ready,
      .dbus_dout,
      .mbus_cmd_valid,
      .mbus_cmd_ready,
      .mbus_cmd_addr,
      .mbus_cmd_we_msk,
      .mbus_din,
      .mbus_valid,
      .mbus_ready,
      .mbus_dout
   );

   l2_cache l2_cache_i (
      .clk,
      .rst,
      .cmd_valid          (mbus_cmd_valid),
      .cmd_ready          (mbus_cmd_ready),
      .cmd_addr           (mbus_cmd_addr),
      .cmd_we_msk         (mbus_cmd_we_msk),
      .din                (mbus_din),
      .valid              (mbus_valid),
      .ready              (mbus_ready),
      .dout               (mbus_dout),
      .flush,
      .flush_done,
      .sdr_cmd_bst_rd_req,
      .sdr_cmd_bst_we_req,
      .sdr_cmd_bst_rd_ack,
      .sdr_cmd_bst_we_ack,
      .sdr_cmd_addr,
      .sdr_din,
      .sdr_dout,
      .sdr_r_vld,
      .sdr_w_rdy
   );

endmodule

`default_nettype wire

/* tb_sdr_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdr_model (
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            sdr_cmd_bst_rd_req,
   input  wire                            sdr_cmd_bst_we_req,
   output logic                           sdr_cmd_bst_rd_ack,
   output logic                           sdr_cmd_bst_we_ack,
   input  wire [fb_pkg::sdr_cmd_aw-1:0]   sdr_cmd_addr,
   input  wire [fb_pkg::sdr_dw-1:0]       sdr_din,
   output logic [fb_pkg::sdr_dw-1:0]      sdr_dout,
   output logic                           sdr_r_vld,
   output logic                           sdr_w_rdy
);

   import fb_pkg::*;

   logic [fb_dw-1:0] mem [int unsigned];   // Written words only
   logic             act;
   logic             is_rd;
   int unsigned      base;
   int               cnt;
   int               gap;
   int unsigned      we_bursts = 0;
   int unsigned      wa;
   logic [fb_dw-1:0] w;

   // Preload pattern, odd multiplier keeps every address bit in play
   function automatic logic [fb_dw-1:0] fill_word(input int unsigned addr);
      return (addr * 32'h9e37_79b1) ^ 32'h3c5a_a5c3;
   endfunction

   function automatic logic [fb_dw-1:0] read_word(input int unsigned addr);
      if (mem.exists(addr))
         return mem[addr];
      return fill_word(addr);
   endfunction

   initial begin
      sdr_cmd_bst_rd_ack = 1'b0;
      sdr_cmd_bst_we_ack = 1'b0;
      sdr_dout           = '0;
      sdr_r_vld          = 1'b0;
      sdr_w_rdy          = 1'b0;
      act                = 1'b0;
   end

   always @(negedge clk) begin
      sdr_cmd_bst_rd_ack <= 1'b0;
      sdr_cmd_bst_we_ack <= 1'b0;
      sdr_r_vld          <= 1'b0;
      sdr_w_rdy          <= 1'b0;
      if (rst) begin
         act <= 1'b0;
      end else if (!act) begin
         if (sdr_cmd_bst_rd_req || sdr_cmd_bst_we_req) begin
            act                <= 1'b1;
            is_rd              <= sdr_cmd_bst_rd_req;
            base               <= sdr_cmd_addr;
            cnt                <= 0;
            gap                <= 1 + $urandom % 3;
            sdr_cmd_bst_rd_ack <= sdr_cmd_bst_rd_req;
            sdr_cmd_bst_we_ack <= sdr_cmd_bst_we_req;
            if (sdr_cmd_bst_we_req)
               we_bursts <= we_bursts + 1;
         end
      end else if (gap != 0) begin
         gap <= gap - 1;   // Idle between strobes
      end else begin
         wa = base + cnt / 2;   // Two halfwords per word, low first
         w  = read_word(wa);
         if (is_rd) begin
            sdr_r_vld <= 1'b1;
            sdr_dout  <= cnt[0] ? w[31:16] : w[15:0];
         end else begin
            sdr_w_rdy <= 1'b1;
            if (cnt[0])
               w[31:16] = sdr_din;
            else
               w[15:0] = sdr_din;
            mem[wa] = w;
         end
         cnt <= cnt + 1;
         gap <= $urandom % 4;
         if (cnt == l2_bst_len - 1)
            act <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* tb_fb_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fb_mem_subsys;

   import fb_pkg::*;

   localparam int bst_max   = 4 + 4 * l2_bst_len;   // Ack plus worst strobe gaps
   localparam int n_ops     = 40;
   localparam int cyc_limit = 200 + l2_lines + n_ops * (2 * bst_max + 24)
                              + l2_lines * bst_max;

   logic               clk;
   logic               rst;
   logic               ibus_cmd_valid;
   logic               ibus_cmd_ready;
   logic [fb_aw-1:0]   ibus_cmd_addr;
   logic               ibus_valid;
   logic               ibus_ready;
   logic [fb_dw-1:0]   ibus_dout;
   logic               dbus_cmd_valid;
   logic               dbus_cmd_ready;
   logic [fb_aw-1:0]   dbus_cmd_addr;
   logic [fb_dw/8-1:0] dbus_cmd_we_msk;
   logic [fb_dw-1:0]   dbus_din;
   logic               dbus_valid;
   logic               dbus_ready;
   logic [fb_dw-1:0]   dbus_dout;
   logic               flush;
   logic               flush_done;
   logic               sdr_cmd_bst_rd_req;
   logic               sdr_cmd_bst_we_req;
   logic               sdr_cmd_bst_rd_ack;
   logic               sdr_cmd_bst_we_ack;
   logic [sdr_cmd_aw-1:0] sdr_cmd_addr;
   logic [sdr_dw-1:0]  sdr_din;
   logic [sdr_dw-1:0]  sdr_dout;
   logic               sdr_r_vld;
   logic               sdr_w_rdy;

   int               cyc = 0;
   int               checks = 0;
   int               errors = 0;
   int               err_mark = 0;
   logic             stall_en = 1'b0;
   logic             d_busy = 1'b0;      // dbus owns the grant
   logic [fb_dw-1:0] ref_mem [int unsigned];

   fb_mem_subsys fb_mem_subsys_i (.*);

   tb_sdr_model tb_sdr_model_i (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= cyc_limit) begin
         $display("Timeout: run exceeded %0d cycles", cyc_limit);
         $display(">>> FAIL");
         $finish;
      end
   end

   a_ibus_hold: assert property (@(posedge clk) disable iff (rst)
      ibus_valid && !ibus_ready |=> ibus_valid && $stable(ibus_dout))
      else begin
         $display("ibus response dropped or changed while stalled");
         errors++;
      end

   a_dbus_hold: assert property (@(posedge clk) disable iff (rst)
      dbus_valid && !dbus_ready |=> dbus_valid && $stable(dbus_dout))
      else begin
         $display("dbus response dropped or changed while stalled");
         errors++;
      end

   a_ibus_blocked: assert property (@(posedge clk) disable iff (rst)
      d_busy |-> !ibus_cmd_ready)
      else begin
         $display("ibus offered the bus while dbus held the grant");
         errors++;
      end

   function automatic logic [fb_aw-1:0] mk_addr(input logic [14:0] tag,
                                                input logic [5:0] idx,
                                                input logic [1:0] word);
      return {tag, idx, word, 2'b00};
   endfunction

   function automatic logic [fb_dw-1:0] ref_read(input int unsigned wa);
      if (ref_mem.exists(wa))
         return ref_mem[wa];
      return tb_sdr_model_i.fill_word(wa);
   endfunction

   function automatic void ref_write(input logic [fb_aw-1:0] a, input logic [3:0] msk,
                                     input logic [fb_dw-1:0] wd);
      logic [fb_dw-1:0] w;
      w = ref_read(a[fb_aw-1:2]);
      for (int b = 0; b < 4; b++)
         if (msk[b])
            w[8*b +: 8] = wd[8*b +: 8];
      ref_mem[a[fb_aw-1:2]] = w;
   endfunction

   function automatic logic pick_ready();
      return stall_en ? logic'($urandom % 3 != 0) : 1'b1;
   endfunction

   task automatic check_word(input string name, input logic [fb_dw-1:0] got,
                             input logic [fb_dw-1:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Handshakes are sampled 1 ns after the falling edge
   task automatic ibus_read(input logic [fb_aw-1:0] a, output logic [fb_dw-1:0] d,
                            output int t_hs, output int t_done);
      logic hs;
      @(negedge clk);
      ibus_cmd_valid = 1'b1;
      ibus_cmd_addr  = a;
      hs = 1'b0;
      while (!hs) begin
         #1 hs = ibus_cmd_ready;
         if (!hs)
            @(negedge clk);
      end
      t_hs = cyc + 1;
      @(negedge clk);
      ibus_cmd_valid = 1'b0;
      hs = 1'b0;
      while (!hs) begin
         ibus_ready = pick_ready();
         #1 hs = ibus_valid && ibus_ready;
         d = ibus_dout;
         if (!hs)
            @(negedge clk);
      end
      t_done = cyc + 1;
      @(negedge clk);
      ibus_ready = 1'b0;
   endtask

   task automatic dbus_access(input logic [fb_aw-1:0] a, input logic [3:0] msk,
                              input logic [fb_dw-1:0] wd, output logic [fb_dw-1:0] d,
                              output int t_hs, output int t_done);
      logic hs;
      @(negedge clk);
      dbus_cmd_valid  = 1'b1;
      dbus_cmd_addr   = a;
      dbus_cmd_we_msk = msk;
      dbus_din        = wd;
      hs = 1'b0;
      while (!hs) begin
         #1 hs = dbus_cmd_ready;
         if (!hs)
            @(negedge clk);
      end
      t_hs = cyc + 1;
      @(negedge clk);
      dbus_cmd_valid = 1'b0;
      d_busy         = 1'b1;
      hs = 1'b0;
      while (!hs) begin
         dbus_ready = pick_ready();
         #1 hs = dbus_valid && dbus_ready;
         d = dbus_dout;
         if (!hs)
            @(negedge clk);
      end
      t_done = cyc + 1;
      @(negedge clk);
      dbus_ready = 1'b0;
      d_busy     = 1'b0;
   endtask

   task automatic write_word(input logic [fb_aw-1:0] a, input logic [3:0] msk,
                             input logic [fb_dw-1:0] wd);
      logic [fb_dw-1:0] d;
      int t0, t1;
      dbus_access(a, msk, wd, d, t0, t1);   // Response data undefined
      ref_write(a, msk, wd);
   endtask

   task automatic read_check(input logic [fb_aw-1:0] a, input logic on_ibus, output int lat);
      logic [fb_dw-1:0] d;
      int t0, t1;
      if (on_ibus)
         ibus_read(a, d, t0, t1);
      else
         dbus_access(a, 4'h0, '0, d, t0, t1);
      check_word(on_ibus ? "ibus_dout" : "dbus_dout", d, ref_read(a[fb_aw-1:2]));
      lat = t1 - t0;
   endtask

   task automatic compare_line(input logic [fb_aw-1:0] a);
      int unsigned wa;
      wa = {a[fb_aw-1:4], 2'b00};
      for (int k = 0; k < l2_words; k++)
         check_word("sdram_word", tb_sdr_model_i.read_word(wa + k), ref_read(wa + k));
   endtask

   task automatic run_flush();
      logic seen;
      @(negedge clk);
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      seen = 1'b0;
      while (!seen) begin
         #1 seen = flush_done;
         if (!seen)
            @(negedge clk);
      end
   endtask

   task automatic report_test(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, errors - err_mark);
      err_mark = errors;
   endtask

   initial begin
      logic [fb_dw-1:0] d_i;
      logic [fb_dw-1:0] d_d;
      logic [fb_aw-1:0] a;
      logic [fb_aw-1:0] fl_addr [5];
      int               t_ih, t_id, t_dh, t_dd, lat;
      int unsigned      bursts;

      void'($urandom(32'h11935c12));
      rst             = 1'b1;
      ibus_cmd_valid  = 1'b0;
      ibus_cmd_addr   = '0;
      ibus_ready      = 1'b0;
      dbus_cmd_valid  = 1'b0;
      dbus_cmd_addr   = '0;
      dbus_cmd_we_msk = '0;
      dbus_din        = '0;
      dbus_ready      = 1'b0;
      flush           = 1'b0;
      repeat (4) @(negedge clk);
      rst = 1'b0;

      a = mk_addr(15'h0123, 6'd5, 2'd2);
      read_check(a, 1'b1, lat);
      read_check(a, 1'b1, lat);
      checks++;
      assert (lat == 1) else begin
         $display("Cache hit answered %0d cycles after acceptance", lat);
         errors++;
      end
      report_test(1, "ibus miss then hit");

      write_word(a, 4'b0110, 32'hdead_beef);
      read_check(a, 1'b0, lat);
      report_test(2, "partial write merge");

      a = mk_addr(15'h0456, 6'd9, 2'd0);
      write_word(a, 4'hf, 32'h1234_5678);
      write_word(a + 25'd12, 4'b1001, 32'h8765_4321);
      bursts = tb_sdr_model_i.we_bursts;
      read_check(mk_addr(15'h0777, 6'd9, 2'd1), 1'b0, lat);   // Same index, new tag
      checks++;
      assert (tb_sdr_model_i.we_bursts == bursts + 1) else begin
         $display("Eviction of a dirty line raised no write burst");
         errors++;
      end
      compare_line(a);
      read_check(a, 1'b1, lat);
      read_check(a + 25'd12, 1'b0, lat);
      report_test(3, "dirty eviction");

      fork
         ibus_read(mk_addr(15'h0222, 6'd40, 2'd3), d_i, t_ih, t_id);
         dbus_access(a, 4'h0, '0, d_d, t_dh, t_dd);
      join
      check_word("dbus_dout", d_d, ref_read(a[fb_aw-1:2]));
      check_word("ibus_dout", d_i, ref_read(mk_addr(15'h0222, 6'd40, 2'd3) >> 2));
      checks++;
      assert (t_dd < t_ih) else begin
         $display("ibus was accepted before the dbus response");
         errors++;
      end
      report_test(4, "same-cycle arbitration");

      for (int i = 0; i < 5; i++) begin
         fl_addr[i] = mk_addr(15'h0100 + 15'(i), 6'(20 + 3 * i), 2'(i));
         write_word(fl_addr[i], 4'($urandom | 1), $urandom);
      end
      run_flush();
      for (int i = 0; i < 5; i++)
         compare_line(fl_addr[i]);
      report_test(5, "flush of dirty lines");

      stall_en = 1'b1;
      for (int n = 0; n < 16; n++) begin
         a = mk_addr(15'($urandom % 4), 6'($urandom % 8), 2'($urandom % 4));
         case ($urandom % 3)
            0: write_word(a, 4'($urandom), $urandom);
            1: read_check(a, 1'b0, lat);
            default: read_check(a, 1'b1, lat);
         endcase
      end
      stall_en = 1'b0;
      report_test(6, "random ready stalls");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
fb_pkg.sv
fb_arbiter.sv
sdr_burst_xfer.sv
l2_cache.sv
fb_mem_subsys.sv
tb_sdr_model.sv
tb_fb_mem_subsys.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then decide on the log contents
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_fb_mem_subsys \
   -f filelist.f -o sim_tb &&
./obj_dir/sim_tb | tee sim.log

grep -q '^>>> PASS$' sim.log && echo "simulation passed" ||
   { echo "simulation failed"; exit 1; }
